// ==== Makefile ====
# Verilator build and run of the ROM loader testbench

VERILATOR ?= verilator
TOP       ?= game_loader_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/game_loader.sv ====
////////////////////////////////////////////////////////////
// ROM image loader top
// FSM, header decoder and section counter
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module game_loader import nes_rom_pkg::*, loader_pkg::*; (
	input  logic          clk,
	input  logic          reset_nes,
	input  byte_t         indata,
	input  logic          indata_clk,
	input  logic          invert_mirroring,
	output mem_write_t    mem,
	output mapper_flags_t mapper_flags,
	output logic          busy,
	output logic          done,
	output logic          error
);

	logic          header_capture;
	logic          header_complete;
	logic          header_valid;
	rom_geometry_t geometry;
	logic          start_prg;
	logic          start_chr;
	logic          advance;
	mem_addr_t     mem_addr;
	logic          section_empty;

	loader_ctrl u_ctrl (
		.clk             (clk),
		.reset_nes       (reset_nes),
		.indata_clk      (indata_clk),
		.header_complete (header_complete),
		.header_valid    (header_valid),
		.section_empty   (section_empty),
		.header_capture  (header_capture),
		.start_prg       (start_prg),
		.start_chr       (start_chr),
		.advance         (advance),
		.busy            (busy),
		.done            (done),
		.error           (error)
	);

	ines_header u_header (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.indata           (indata),
		.header_capture   (header_capture),
		.invert_mirroring (invert_mirroring),
		.header_complete  (header_complete),
		.header_valid     (header_valid),
		.geometry         (geometry),
		.mapper_flags     (mapper_flags)
	);

	load_counter u_counter (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.start_prg     (start_prg),
		.start_chr     (start_chr),
		.advance       (advance),
		.geometry      (geometry),
		.mem_addr      (mem_addr),
		.section_empty (section_empty)
	);

	// Each accepted ROM byte goes straight out with its address
	assign mem = '{addr: mem_addr, data: indata, write: advance};

endmodule

// ==== design/ines_header.sv ====
////////////////////////////////////////////////////////////
// iNES header capture and check
// Size class coding and mapper flag decoding
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ines_header import nes_rom_pkg::*; (
	input  logic          clk,
	input  logic          reset_nes,
	input  byte_t         indata,
	input  logic          header_capture,
	input  logic          invert_mirroring,
	output logic          header_complete,
	output logic          header_valid,
	output rom_geometry_t geometry,
	output mapper_flags_t mapper_flags
);

	byte_t      hdr [INES_HEADER_BYTES];
	logic [3:0] hdr_idx;
	logic       is_nes20;
	logic       is_dirty;
	logic       tail_nonzero;

	// Smallest n with pages <= 2^n, saturating at 7
	function automatic size_code_t size_code(input page_count_t pages);
		size_code_t code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if (int'(pages) <= (1 << n))
				code = size_code_t'(n);
		end
		return code;
	endfunction

	////////////////////////////////////////////////////////////
	// Byte capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (header_capture)
			hdr[hdr_idx] <= indata;
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			hdr_idx <= '0;
		else if (header_capture)
			hdr_idx <= hdr_idx + 4'd1;  // Wraps after byte 15
	end

	// Last header byte on its way in
	assign header_complete = header_capture && (hdr_idx == 4'(INES_HEADER_BYTES - 1));

	// Signature plus no trainer; all five bytes are already stored here
	assign header_valid = (hdr[0] == INES_MAGIC_0) && (hdr[1] == INES_MAGIC_1) &&
	                      (hdr[2] == INES_MAGIC_2) && (hdr[3] == INES_MAGIC_3) &&
	                      !hdr[6][2];

	assign geometry.prg_pages = hdr[4];
	assign geometry.chr_pages = hdr[5];

	////////////////////////////////////////////////////////////
	// Flag decoding
	////////////////////////////////////////////////////////////

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Junk in the tail of an old iNES 1.0 header
	always_comb begin
		tail_nonzero = (hdr[9][7:1] != 7'd0);
		for (int i = 10; i < INES_HEADER_BYTES; i++) begin
			if (hdr[i] != 8'h00)
				tail_nonzero = 1'b1;
		end
	end

	assign is_dirty = !is_nes20 && tail_nonzero;

	always_comb begin
		mapper_flags.mapper        = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
		mapper_flags.prg_size      = size_code(hdr[4]);
		mapper_flags.chr_size      = size_code(hdr[5]);
		mapper_flags.mirroring     = hdr[6][0] ^ invert_mirroring;
		mapper_flags.chr_ram       = (hdr[5] == 8'h00);  // No CHR ROM pages
		mapper_flags.four_screen   = hdr[6][3];
		mapper_flags.submapper     = is_nes20 ? hdr[8] : 8'h00;
		mapper_flags.has_saves     = hdr[6][1];          // Battery bit
		mapper_flags.prg_ram_shift = is_nes20 ? hdr[10][3:0] : 4'h0;
	end

endmodule

// ==== design/load_counter.sv ====
////////////////////////////////////////////////////////////
// Write address and remaining byte counter
// for the PRG and CHR sections
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module load_counter import nes_rom_pkg::*, loader_pkg::*; (
	input  logic          clk,
	input  logic          reset_nes,
	input  logic          start_prg,
	input  logic          start_chr,
	input  logic          advance,
	input  rom_geometry_t geometry,
	output mem_addr_t     mem_addr,
	output logic          section_empty
);

	byte_count_t count;
	byte_count_t prg_bytes;
	byte_count_t chr_bytes;

	// Section lengths from the page counts
	assign prg_bytes = byte_count_t'(geometry.prg_pages) << PRG_PAGE_SHIFT;
	assign chr_bytes = byte_count_t'(geometry.chr_pages) << CHR_PAGE_SHIFT;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			mem_addr <= '0;
			count    <= '0;
		end else if (start_prg) begin
			mem_addr <= PRG_BASE;
			count    <= prg_bytes;
		end else if (start_chr) begin
			mem_addr <= CHR_BASE;
			count    <= chr_bytes;
		end else if (advance) begin
			mem_addr <= mem_addr + 22'd1;
			count    <= count - 22'd1;
		end
	end

	assign section_empty = (count == '0);

endmodule

// ==== design/loader_ctrl.sv ====
////////////////////////////////////////////////////////////
// Loader FSM
// Header, PRG and CHR sequencing with busy, done and error
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module loader_ctrl import loader_pkg::*; (
	input  logic clk,
	input  logic reset_nes,
	input  logic indata_clk,
	input  logic header_complete,
	input  logic header_valid,
	input  logic section_empty,
	output logic header_capture,
	output logic start_prg,
	output logic start_chr,
	output logic advance,
	output logic busy,
	output logic done,
	output logic error
);

	loader_state_t state;
	logic          in_section;

	assign in_section = (state == ST_PRG) || (state == ST_CHR);

	////////////////////////////////////////////////////////////
	// Strobe steering
	////////////////////////////////////////////////////////////

	assign header_capture = (state == ST_HEADER) && indata_clk;

	// Byte strobes past the end of a section are dropped
	assign advance = in_section && indata_clk && !section_empty;

	assign start_prg = (state == ST_HEADER) && header_complete && header_valid;
	assign start_chr = (state == ST_PRG) && section_empty;

	////////////////////////////////////////////////////////////
	// State and status
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state <= ST_HEADER;
			busy  <= 1'b0;
			done  <= 1'b0;
			error <= 1'b0;
		end else begin
			case (state)
				ST_HEADER: begin
					if (header_complete) begin
						busy  <= 1'b1;
						state <= header_valid ? ST_PRG : ST_ERROR;
					end
				end

				ST_PRG: begin
					if (section_empty)
						state <= ST_CHR;  // Counter reloads on start_chr
				end

				ST_CHR: begin
					// Zero CHR pages ends here right away
					if (section_empty) begin
						state <= ST_DONE;
						done  <= 1'b1;
						busy  <= 1'b0;
					end
				end

				ST_ERROR: begin
					done  <= 1'b1;
					error <= 1'b1;
					busy  <= 1'b0;
				end

				ST_DONE: begin
					done <= 1'b1;  // Holds until reset
					busy <= 1'b0;
				end

				default: state <= ST_HEADER;
			endcase
		end
	end

endmodule

// ==== design/loader_pkg.sv ====
////////////////////////////////////////////////////////////
// Loader memory map, state encoding and write bus types
////////////////////////////////////////////////////////////

package loader_pkg;

	typedef logic [21:0] mem_addr_t;
	typedef logic [21:0] byte_count_t;  // Bytes left in a section

	// One memory write, valid in the cycle write is high
	typedef struct packed {
		mem_addr_t          addr;
		nes_rom_pkg::byte_t data;
		logic               write;
	} mem_write_t;

	typedef enum logic [2:0] {
		ST_HEADER,
		ST_PRG,
		ST_CHR,
		ST_ERROR,
		ST_DONE
	} loader_state_t;

	////////////////////////////////////////////////////////////
	// Memory map
	////////////////////////////////////////////////////////////

	localparam mem_addr_t PRG_BASE = 22'h000000;
	localparam mem_addr_t CHR_BASE = 22'h200000;  // CHR half of the map

endpackage

// ==== design/nes_rom_pkg.sv ====
////////////////////////////////////////////////////////////
// iNES file format types and constants
// Header geometry and decoded mapper flags word
////////////////////////////////////////////////////////////

package nes_rom_pkg;

	typedef logic [7:0] byte_t;        // One byte of the image
	typedef logic [7:0] page_count_t;  // PRG or CHR page count from header
	typedef logic [2:0] size_code_t;   // Log2 size class
	typedef logic [7:0] mapper_num_t;

	// Decoded header, handed to the mapper logic
	typedef struct packed {
		logic [3:0]  prg_ram_shift;  // NES 2.0 only
		logic        has_saves;
		logic [7:0]  submapper;      // NES 2.0 only
		logic        four_screen;
		logic        chr_ram;
		logic        mirroring;
		size_code_t  chr_size;
		size_code_t  prg_size;
		mapper_num_t mapper;
	} mapper_flags_t;

	typedef struct packed {
		page_count_t prg_pages;
		page_count_t chr_pages;
	} rom_geometry_t;

	////////////////////////////////////////////////////////////
	// Format constants
	////////////////////////////////////////////////////////////

	localparam int INES_HEADER_BYTES = 16;

	// "NES" followed by 1Ah
	localparam byte_t INES_MAGIC_0 = 8'h4E;
	localparam byte_t INES_MAGIC_1 = 8'h45;
	localparam byte_t INES_MAGIC_2 = 8'h53;
	localparam byte_t INES_MAGIC_3 = 8'h1A;

	localparam int PRG_PAGE_SHIFT = 14;  // 16 KiB pages
	localparam int CHR_PAGE_SHIFT = 13;  // 8 KiB pages

endpackage

// ==== src.f ====
design/nes_rom_pkg.sv
design/loader_pkg.sv
design/ines_header.sv
design/load_counter.sv
design/loader_ctrl.sv
design/game_loader.sv
test/game_loader_assertions.sv
test/game_loader_tb.sv

// ==== test/game_loader_assertions.sv ====
////////////////////////////////////////////////////////////
// Status and write protocol assertions for the loader top
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module game_loader_assertions (
	input logic clk,
	input logic reset_nes,
	input logic busy,
	input logic done,
	input logic error,
	input logic mem_write
);

	logic done_fell   = 1'b0;
	logic error_alone = 1'b0;
	logic busy_done   = 1'b0;
	logic stray_write = 1'b0;
	logic any_failed;

	assign any_failed = done_fell || error_alone || busy_done || stray_write;

	// Done is sticky until the next reset
	done_holds: assert property (@(posedge clk) (!reset_nes && done) |=> done)
		else begin
			done_fell = 1'b1;
			$error("done fell without a reset");
		end

	error_has_done: assert property (@(posedge clk) disable iff (reset_nes) error |-> done)
		else begin
			error_alone = 1'b1;
			$error("error high while done is low");
		end

	busy_not_done: assert property (@(posedge clk) disable iff (reset_nes) !(busy && done))
		else begin
			busy_done = 1'b1;
			$error("busy and done high together");
		end

	write_in_busy: assert property (@(posedge clk) disable iff (reset_nes) mem_write |-> busy)
		else begin
			stray_write = 1'b1;
			$error("memory write outside busy");
		end

endmodule

bind game_loader game_loader_assertions u_assertions (
	.clk       (clk),
	.reset_nes (reset_nes),
	.busy      (busy),
	.done      (done),
	.error     (error),
	.mem_write (mem.write)
);

// ==== test/game_loader_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the ROM image loader
// Image generator, reference flags model and write checker
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module game_loader_tb import nes_rom_pkg::*, loader_pkg::*; ();

	typedef enum int {HDR_CLEAN, HDR_DIRTY, HDR_NES20} header_kind_t;

	localparam int DONE_TIMEOUT = 64;  // Cycles after the last byte

	logic          clk;
	logic          reset_nes;
	byte_t         indata;
	logic          indata_clk;
	logic          invert_mirroring;
	mem_write_t    mem;
	mapper_flags_t mapper_flags;
	logic          busy;
	logic          done;
	logic          error;

	byte_t      header [INES_HEADER_BYTES];
	mem_write_t expected_writes [$];
	mem_write_t want;
	string      test_name;

	game_loader i_dut (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.indata           (indata),
		.indata_clk       (indata_clk),
		.invert_mirroring (invert_mirroring),
		.mem              (mem),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////////////////////////

	function automatic size_code_t expected_size(input page_count_t pages);
		int n;
		n = 0;
		while (n < 7 && int'(pages) > (1 << n))
			n++;
		return size_code_t'(n);
	endfunction

	function automatic mapper_flags_t expected_flags(input byte_t h [INES_HEADER_BYTES],
	                                                 input logic invert);
		mapper_flags_t f;
		logic          nes20;
		logic          dirty;
		byte_t         tail;
		nes20 = (h[7][3:2] == 2'b10);
		tail  = {h[9][7:1], 1'b0} | h[10] | h[11] | h[12] | h[13] | h[14] | h[15];
		dirty = !nes20 && (tail != 8'h00);
		f = '0;
		f.mapper = {h[7][7:4], h[6][7:4]};
		if (dirty)
			f.mapper[7:4] = 4'h0;  // Old rippers left junk in the tail
		f.prg_size    = expected_size(h[4]);
		f.chr_size    = expected_size(h[5]);
		f.mirroring   = h[6][0] ^ invert;
		f.chr_ram     = (h[5] == 8'h00);
		f.four_screen = h[6][3];
		f.has_saves   = h[6][1];
		if (nes20) begin
			f.submapper     = h[8];
			f.prg_ram_shift = h[10][3:0];
		end
		return f;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [63:0] expected,
	                           input logic [63:0] actual);
		if (expected !== actual)
			abort_run($sformatf("FAILED %s: %s expected %0h actual %0h",
			                    test_name, what, expected, actual));
	endtask

	// Every write must match the next expected one
	always @(negedge clk) begin
		if (mem.write) begin
			if (expected_writes.size() == 0) begin
				abort_run($sformatf("Unexpected memory write to %h in %s", mem.addr, test_name));
			end else begin
				want = expected_writes.pop_front();
				check_value("write address", 64'(want.addr), 64'(mem.addr));
				check_value("write data", 64'(want.data), 64'(mem.data));
			end
		end
	end

	always @(negedge clk) begin
		if (i_dut.u_assertions.any_failed)
			abort_run($sformatf("A protocol assertion failed during %s", test_name));
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clk);
		reset_nes  <= 1'b1;
		indata_clk <= 1'b0;
		repeat (8) @(posedge clk);
		reset_nes <= 1'b0;
	endtask

	// One strobe, then two idle cycles
	task automatic send_byte(input byte_t b);
		@(posedge clk);
		indata     <= b;
		indata_clk <= 1'b1;
		@(posedge clk);
		indata_clk <= 1'b0;
		@(posedge clk);
	endtask

	task automatic build_header(input header_kind_t kind, input page_count_t prg_pages,
	                            input page_count_t chr_pages);
		header[0] = INES_MAGIC_0;
		header[1] = INES_MAGIC_1;
		header[2] = INES_MAGIC_2;
		header[3] = INES_MAGIC_3;
		header[4] = prg_pages;
		header[5] = chr_pages;
		header[6] = byte_t'($urandom) & 8'hFB;  // Trainer bit clear
		header[7] = byte_t'($urandom);
		for (int i = 8; i < INES_HEADER_BYTES; i++)
			header[i] = (kind == HDR_NES20) ? byte_t'($urandom) : 8'h00;
		header[7][3:2] = (kind == HDR_NES20) ? 2'b10 : 2'b00;
		if (kind != HDR_NES20) begin
			header[8] = byte_t'($urandom);
			header[9] = byte_t'($urandom) & 8'h01;
		end
		if (kind == HDR_DIRTY)
			header[10 + int'($urandom % 6)] = byte_t'($urandom) | 8'h01;
	endtask

	task automatic send_header();
		for (int i = 0; i < INES_HEADER_BYTES; i++)
			send_byte(header[i]);
	endtask

	// Random ROM bytes, queued as expected writes when they must land
	task automatic send_section(input mem_addr_t base, input int unsigned count,
	                            input logic expect_write);
		byte_t b;
		for (int unsigned i = 0; i < count; i++) begin
			b = byte_t'($urandom);
			if (expect_write)
				expected_writes.push_back(mem_write_t'{addr: base + mem_addr_t'(i),
				                                       data: b, write: 1'b1});
			send_byte(b);
		end
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!done && cycles < DONE_TIMEOUT);
		if (!done)
			abort_run($sformatf("Timed out waiting for done in %s", test_name));
	endtask

	task automatic check_status(input logic exp_busy, input logic exp_done, input logic exp_err);
		check_value("busy", 64'(exp_busy), 64'(busy));
		check_value("done", 64'(exp_done), 64'(done));
		check_value("error", 64'(exp_err), 64'(error));
		check_value("pending writes", 64'(0), 64'(expected_writes.size()));
	endtask

	task automatic load_image(input logic invert);
		@(posedge clk);
		invert_mirroring <= invert;
		send_header();
		send_section(PRG_BASE, int'(header[4]) << PRG_PAGE_SHIFT, 1'b1);
		send_section(CHR_BASE, int'(header[5]) << CHR_PAGE_SHIFT, 1'b1);
		wait_done();
		check_status(1'b0, 1'b1, 1'b0);
		check_value("mapper_flags", 64'(expected_flags(header, invert)), 64'(mapper_flags));
	endtask

	initial begin
		clk              = 1'b0;
		reset_nes        = 1'b1;
		indata           = 8'h00;
		indata_clk       = 1'b0;
		invert_mirroring = 1'b0;
		void'($urandom(32'h11ee1fb6));
		test_name = "basic_load";
		apply_reset();
		build_header(HDR_CLEAN, 8'd1, 8'd1);
		load_image(1'b0);

		// Every header kind with both mirroring inputs
		for (int i = 0; i < 6; i++) begin
			test_name = $sformatf("flags_%0d", i);
			apply_reset();
			build_header(header_kind_t'(i % 3), page_count_t'($urandom % 3),
			             page_count_t'($urandom % 3));
			load_image(i[0]);
		end

		test_name = "zero_chr";
		apply_reset();
		build_header(HDR_NES20, 8'd1, 8'd0);
		load_image(1'b0);
		check_value("chr_ram", 64'(1), 64'(mapper_flags.chr_ram));
		send_section(CHR_BASE, 8, 1'b0);

		test_name = "bad_signature";
		apply_reset();
		build_header(HDR_CLEAN, 8'd1, 8'd1);
		header[int'($urandom % 4)] ^= byte_t'($urandom) | 8'h01;
		send_header();
		wait_done();
		check_status(1'b0, 1'b1, 1'b1);
		send_section(PRG_BASE, 32, 1'b0);

		test_name = "trainer";
		apply_reset();
		build_header(HDR_CLEAN, 8'd1, 8'd1);
		header[6][2] = 1'b1;
		send_header();
		wait_done();
		send_section(PRG_BASE, 64, 1'b0);
		check_status(1'b0, 1'b1, 1'b1);

		test_name = "reset_mid_prg";
		apply_reset();
		build_header(HDR_CLEAN, 8'd2, 8'd1);
		send_header();
		send_section(PRG_BASE, 300, 1'b1);
		@(negedge clk);
		check_status(1'b1, 1'b0, 1'b0);
		apply_reset();
		@(negedge clk);
		check_status(1'b0, 1'b0, 1'b0);
		build_header(HDR_NES20, 8'd1, 8'd1);
		load_image(1'b1);

		$display("Finished with no errors");
		$finish;
	end

endmodule
